// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_attn_core
BUILD_DIR ?= build
LOG       ?= sim.log
FLIST     ?= flist.f

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard testbench/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx 'Finished with no errors' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
+incdir+testbench
hdl/attn_pkg.sv
hdl/attn_ctrl.sv
hdl/token_store.sv
hdl/projection_unit.sv
hdl/score_unit.sv
hdl/context_unit.sv
hdl/attn_core.sv
testbench/tb_attn_core.sv

// ==== hdl/attn_core.sv ====
// attention engine top; no back-pressure, in_valid must stay high for all 192 load beats
`timescale 1ns/10ps

module attn_core (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  attn_pkg::seq_len_t seq_len,
    input  attn_pkg::data_t    in_data,
    input  attn_pkg::data_t    w_q,
    input  attn_pkg::data_t    w_k,
    input  attn_pkg::data_t    w_v,
    output logic               out_valid,
    output attn_pkg::out_t     out_data
);
    import attn_pkg::*;

    phase_t            phase;
    logic [BEAT_W-1:0] beat;
    seq_len_t          seq_len_q;
    data_row_t         token_col;
    data_t             wq_elem;
    proj_row_t         q_row;
    proj_row_t         k_row;
    proj_row_t         v_col;
    score_row_t        score_row;

    attn_ctrl attn_ctrl_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .seq_len   (seq_len),
        .phase     (phase),
        .beat      (beat),
        .seq_len_q (seq_len_q)
    );

    token_store token_store_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (in_data),
        .w_q       (w_q),
        .phase     (phase),
        .beat      (beat),
        .seq_len_q (seq_len_q),
        .token_col (token_col),
        .wq_elem   (wq_elem)
    );

    projection_unit projection_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .beat      (beat),
        .token_col (token_col),
        .wq_elem   (wq_elem),
        .w_k       (w_k),
        .w_v       (w_v),
        .q_row     (q_row),
        .k_row     (k_row),
        .v_col     (v_col)
    );

    score_unit score_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .beat      (beat),
        .q_row     (q_row),
        .k_row     (k_row),
        .score_row (score_row)
    );

    context_unit context_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .score_row (score_row),
        .v_col     (v_col),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// ==== hdl/attn_ctrl.sv ====
// phase sequencer; seq_len outside 1..8 is unsupported and a new load must wait for out_valid low
`timescale 1ns/10ps

module attn_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  attn_pkg::seq_len_t          seq_len,
    output attn_pkg::phase_t            phase,
    output logic [attn_pkg::BEAT_W-1:0] beat,
    output attn_pkg::seq_len_t          seq_len_q
);
    import attn_pkg::*;

    phase_t            phase_nxt;
    logic [BEAT_W-1:0] beat_nxt;
    logic [BEAT_W:0]   burst_len;
    logic              load_last;
    logic              burst_last;

    // one output per element of a T x 8 result
    assign burst_len  = (BEAT_W+1)'(seq_len_q) * (BEAT_W+1)'(DIM);
    assign load_last  = (beat == BEAT_W'(BEATS_PER_PHASE - 1));
    assign burst_last = ({1'b0, beat} == burst_len - 1'b1);

    always_comb begin
        phase_nxt = phase;
        beat_nxt  = beat + 1'b1;
        case (phase)
            PH_IDLE: begin
                beat_nxt = '0;
                // the idle edge with in_valid high already takes beat 0
                if (in_valid) begin
                    phase_nxt = PH_LOAD_Q;
                    beat_nxt  = BEAT_W'(1);
                end
            end
            PH_LOAD_Q: begin
                if (load_last) begin
                    phase_nxt = PH_LOAD_K;
                end
            end
            PH_LOAD_K: begin
                if (load_last) begin
                    phase_nxt = PH_LOAD_V;
                end
            end
            PH_LOAD_V: begin
                if (load_last) begin
                    phase_nxt = PH_OUTPUT;
                end
            end
            PH_OUTPUT: begin
                if (burst_last) begin
                    phase_nxt = PH_IDLE;
                    beat_nxt  = '0;
                end
            end
            default: begin
                phase_nxt = PH_IDLE;
                beat_nxt  = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= PH_IDLE;
            beat      <= '0;
            seq_len_q <= seq_len_t'(1);
        end else begin
            phase <= phase_nxt;
            beat  <= beat_nxt;
            if (phase == PH_IDLE && in_valid) begin
                seq_len_q <= seq_len;
            end
        end
    end

endmodule

// ==== hdl/attn_pkg.sv ====
// sizes, element types and phase encoding for the attention engine; T is limited to 1..8
package attn_pkg;

    localparam int DIM             = 8;
    localparam int BEATS_PER_PHASE = 64;
    localparam int BEAT_W          = 6;
    localparam int SCORE_DIVISOR   = 3;

    typedef logic signed [7:0]  data_t;
    typedef logic        [3:0]  seq_len_t;
    // eight 8x8 products
    typedef logic signed [18:0] proj_t;
    // eight 19x19 products
    typedef logic signed [39:0] score_t;
    typedef logic signed [63:0] out_t;

    typedef data_t  data_row_t  [DIM];
    typedef proj_t  proj_row_t  [DIM];
    typedef score_t score_row_t [DIM];

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_LOAD_Q,
        PH_LOAD_K,
        PH_LOAD_V,
        PH_OUTPUT
    } phase_t;

endpackage

// ==== hdl/context_unit.sv ====
// output stage; each element is registered one cycle after its burst beat
`timescale 1ns/10ps

module context_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  attn_pkg::phase_t      phase,
    input  attn_pkg::score_row_t  score_row,
    input  attn_pkg::proj_row_t   v_col,
    output logic                  out_valid,
    output attn_pkg::out_t        out_data
);
    import attn_pkg::*;

    out_t dot;

    // score row times V column
    always_comb begin
        dot = '0;
        for (int n = 0; n < DIM; n++) begin
            dot = dot + out_t'(score_row[n]) * out_t'(v_col[n]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else if (phase == PH_OUTPUT) begin
            out_valid <= 1'b1;
            out_data  <= dot;
        end else begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end
    end

endmodule

// ==== hdl/projection_unit.sv ====
// Q, K and V accumulators; Q and K finish in the K phase, V in the V phase
`timescale 1ns/10ps

module projection_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  attn_pkg::phase_t            phase,
    input  logic [attn_pkg::BEAT_W-1:0] beat,
    input  attn_pkg::data_row_t         token_col,
    input  attn_pkg::data_t             wq_elem,
    input  attn_pkg::data_t             w_k,
    input  attn_pkg::data_t             w_v,
    output attn_pkg::proj_row_t         q_row,
    output attn_pkg::proj_row_t         k_row,
    output attn_pkg::proj_row_t         v_col
);
    import attn_pkg::*;

    proj_t q_mat   [DIM][DIM];
    proj_t k_mat   [DIM][DIM];
    proj_t v_mat   [DIM][DIM];
    proj_t q_prod  [DIM];
    proj_t kv_prod [DIM];
    data_t kv_w;

    // second lane set serves K, then V
    assign kv_w = (phase == PH_LOAD_V) ? w_v : w_k;

    always_comb begin
        for (int i = 0; i < DIM; i++) begin
            q_prod[i]  = proj_t'(token_col[i]) * proj_t'(wq_elem);
            kv_prod[i] = proj_t'(token_col[i]) * proj_t'(kv_w);
        end
    end

    // beat carries weight row beat[5:3], column beat[2:0]
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DIM; i++) begin
                for (int j = 0; j < DIM; j++) begin
                    q_mat[i][j] <= '0;
                    k_mat[i][j] <= '0;
                    v_mat[i][j] <= '0;
                end
            end
        end else begin
            case (phase)
                PH_LOAD_Q: begin
                    // fresh sequence
                    for (int i = 0; i < DIM; i++) begin
                        for (int j = 0; j < DIM; j++) begin
                            q_mat[i][j] <= '0;
                            k_mat[i][j] <= '0;
                            v_mat[i][j] <= '0;
                        end
                    end
                end
                PH_LOAD_K: begin
                    for (int i = 0; i < DIM; i++) begin
                        q_mat[i][beat[2:0]] <= q_mat[i][beat[2:0]] + q_prod[i];
                        k_mat[i][beat[2:0]] <= k_mat[i][beat[2:0]] + kv_prod[i];
                    end
                end
                PH_LOAD_V: begin
                    for (int i = 0; i < DIM; i++) begin
                        v_mat[i][beat[2:0]] <= v_mat[i][beat[2:0]] + kv_prod[i];
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        for (int n = 0; n < DIM; n++) begin
            // score beat i*8+k pairs Q row i with K row k
            q_row[n] = q_mat[beat[5:3]][n];
            k_row[n] = k_mat[beat[2:0]][n];
            // output beat i*8+j reads V column j
            v_col[n] = v_mat[n][beat[2:0]];
        end
    end

endmodule

// ==== hdl/score_unit.sv ====
// score matrix; one relu(q.k)/3 entry per V-phase beat, rows read back during the burst
`timescale 1ns/10ps

module score_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  attn_pkg::phase_t            phase,
    input  logic [attn_pkg::BEAT_W-1:0] beat,
    input  attn_pkg::proj_row_t         q_row,
    input  attn_pkg::proj_row_t         k_row,
    output attn_pkg::score_row_t        score_row
);
    import attn_pkg::*;

    score_t s_mem [DIM][DIM];
    score_t dot;
    score_t scaled;

    always_comb begin
        dot = '0;
        for (int n = 0; n < DIM; n++) begin
            dot = dot + score_t'(q_row[n]) * score_t'(k_row[n]);
        end
        // relu, then truncating divide
        scaled = (dot < 0) ? '0 : dot / SCORE_DIVISOR;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DIM; i++) begin
                for (int k = 0; k < DIM; k++) begin
                    s_mem[i][k] <= '0;
                end
            end
        end else if (phase == PH_LOAD_V) begin
            s_mem[beat[5:3]][beat[2:0]] <= scaled;
        end
    end

    // burst beat i*8+j uses score row i
    always_comb begin
        for (int n = 0; n < DIM; n++) begin
            score_row[n] = s_mem[beat[5:3]][n];
        end
    end

endmodule

// ==== hdl/token_store.sv ====
// token and Q weight storage; a token row past seq_len_q is stored as zero
`timescale 1ns/10ps

module token_store (
    input  logic                        clk,
    input  logic                        rst_n,
    input  attn_pkg::data_t             in_data,
    input  attn_pkg::data_t             w_q,
    input  attn_pkg::phase_t            phase,
    input  logic [attn_pkg::BEAT_W-1:0] beat,
    input  attn_pkg::seq_len_t          seq_len_q,
    output attn_pkg::data_row_t         token_col,
    output attn_pkg::data_t             wq_elem
);
    import attn_pkg::*;

    data_t           x_mem  [BEATS_PER_PHASE];
    data_t           wq_mem [BEATS_PER_PHASE];
    logic [BEAT_W:0] valid_beats;
    logic            load_en;
    data_t           x_in;

    assign valid_beats = (BEAT_W+1)'(seq_len_q) * (BEAT_W+1)'(DIM);

    // idle keeps rewriting slot 0, so the beat taken with in_valid is what stays.
    // beat 0 is always inside the sequence, even against a stale seq_len_q
    assign load_en = (phase == PH_IDLE) || (phase == PH_LOAD_Q);
    assign x_in    = ({1'b0, beat} < valid_beats) ? in_data : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < BEATS_PER_PHASE; n++) begin
                x_mem[n]  <= '0;
                wq_mem[n] <= '0;
            end
        end else if (load_en) begin
            x_mem[beat]  <= x_in;
            wq_mem[beat] <= w_q;
        end
    end

    // column of X matching the weight row of this beat
    always_comb begin
        for (int i = 0; i < DIM; i++) begin
            token_col[i] = x_mem[i * DIM + int'(beat[5:3])];
        end
    end

    assign wq_elem = wq_mem[beat];

endmodule

// ==== testbench/attn_ref_model.svh ====
// reference model for the attention engine; x_mat, wq_m, wk_m, wv_m and exp_out must be in scope
`ifndef ATTN_REF_MODEL_SVH
`define ATTN_REF_MODEL_SVH

int unsigned lcg_state = 67;

// full-range signed 8-bit element from the upper LCG bits
function automatic int lcg_elem();
    byte r;
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    r = byte'(lcg_state >> 16);
    return int'(r);
endfunction

// fills exp_out with the T x 8 result, rows row-major
function automatic void compute_expected(input int t);
    longint q [DIM][DIM];
    longint k [DIM][DIM];
    longint v [DIM][DIM];
    longint s [DIM][DIM];
    longint xe;
    longint acc;
    for (int i = 0; i < DIM; i++) begin
        for (int j = 0; j < DIM; j++) begin
            q[i][j] = 0;
            k[i][j] = 0;
            v[i][j] = 0;
            for (int n = 0; n < DIM; n++) begin
                // token rows at or past t count as zero
                xe = (i < t) ? longint'(x_mat[i * DIM + n]) : 64'sd0;
                q[i][j] = q[i][j] + xe * longint'(wq_m[n * DIM + j]);
                k[i][j] = k[i][j] + xe * longint'(wk_m[n * DIM + j]);
                v[i][j] = v[i][j] + xe * longint'(wv_m[n * DIM + j]);
            end
        end
    end
    for (int i = 0; i < DIM; i++) begin
        for (int kr = 0; kr < DIM; kr++) begin
            acc = 0;
            for (int n = 0; n < DIM; n++) begin
                acc = acc + q[i][n] * k[kr][n];
            end
            // relu, then divide by three
            s[i][kr] = (acc < 0) ? 64'sd0 : acc / 3;
        end
    end
    for (int i = 0; i < t; i++) begin
        for (int j = 0; j < DIM; j++) begin
            acc = 0;
            for (int n = 0; n < DIM; n++) begin
                acc = acc + s[i][n] * v[n][j];
            end
            exp_out[i * DIM + j] = acc;
        end
    end
endfunction

`endif

// ==== testbench/tb_attn_core.sv ====
// directed testbench for attn_core; every load is 192 contiguous beats and T stays within 1..8
`timescale 1ns/10ps

module tb_attn_core;
    import attn_pkg::*;

    localparam int DRIVE_DLY  = 10;
    localparam int WAIT_LIMIT = 400;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    seq_len_t seq_len;
    data_t    in_data;
    data_t    w_q;
    data_t    w_k;
    data_t    w_v;
    logic     out_valid;
    out_t     out_data;

    int     x_mat   [BEATS_PER_PHASE];
    int     wq_m    [BEATS_PER_PHASE];
    int     wk_m    [BEATS_PER_PHASE];
    int     wv_m    [BEATS_PER_PHASE];
    longint exp_out [BEATS_PER_PHASE];
    int     data_errors  = 0;
    int     proto_errors = 0;

    `include "attn_ref_model.svh"

    attn_core attn_core_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .seq_len   (seq_len),
        .in_data   (in_data),
        .w_q       (w_q),
        .w_k       (w_k),
        .w_v       (w_v),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic wait_out_level(input string name, input logic level, output int cycles);
        cycles = 0;
        while (out_valid !== level && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (out_valid !== level) begin
            $display("%s: out_valid did not reach %0b within %0d cycles", name, level, WAIT_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    endtask

    // Q weights with tokens, then K, then V
    task automatic drive_load(input int t);
        for (int n = 0; n < 3 * BEATS_PER_PHASE; n++) begin
            in_valid = 1'b1;
            seq_len  = (n == 0) ? seq_len_t'(t) : '0;
            in_data  = (n < 64) ? data_t'(x_mat[n % 64]) : '0;
            w_q      = (n < 64) ? data_t'(wq_m[n % 64]) : '0;
            w_k      = (n >= 64 && n < 128) ? data_t'(wk_m[n % 64]) : '0;
            w_v      = (n >= 128) ? data_t'(wv_m[n % 64]) : '0;
            next_cycle();
        end
        in_valid = 1'b0;
        seq_len  = '0;
        in_data  = '0;
        w_q      = '0;
        w_k      = '0;
        w_v      = '0;
    endtask

    task automatic check_burst(input string name, input int t);
        int total;
        int extra;
        bit short_burst;
        total       = t * DIM;
        short_burst = 1'b0;
        for (int idx = 0; idx < total && !short_burst; idx++) begin
            if (!out_valid) begin
                $display("%s: burst stopped after %0d of %0d outputs", name, idx, total);
                proto_errors++;
                short_burst = 1'b1;
            end else begin
                if (out_data !== exp_out[idx]) begin
                    $display("CHECK FAILED %s out[%0d]: expected %0d, actual %0d",
                             name, idx, exp_out[idx], out_data);
                    data_errors++;
                end
                next_cycle();
            end
        end
        if (!short_burst) begin
            wait_out_level(name, 1'b0, extra);
            if (extra != 0) begin
                $display("%s: burst ran %0d cycles past %0d outputs", name, extra, total);
                proto_errors++;
            end
        end
    endtask

    task automatic run_sequence(input string name, input int t);
        int latency;
        compute_expected(t);
        drive_load(t);
        wait_out_level(name, 1'b1, latency);
        // out_valid seen one edge after the last load edge
        if (latency != 1) begin
            $display("CHECK FAILED %s latency: expected 1, actual %0d", name, latency);
            data_errors++;
        end
        check_burst(name, t);
    endtask

    task automatic fill_random();
        for (int n = 0; n < BEATS_PER_PHASE; n++) begin
            x_mat[n] = lcg_elem();
            wq_m[n]  = lcg_elem();
            wk_m[n]  = lcg_elem();
            wv_m[n]  = lcg_elem();
        end
    endtask

    task automatic check_reset_state();
        repeat (16) begin
            if (out_valid !== 1'b0 || out_data !== '0) begin
                $display("CHECK FAILED reset_state: expected valid 0 data 0, actual valid %0b data %0d",
                         out_valid, out_data);
                data_errors++;
            end
            next_cycle();
        end
    endtask

    task automatic test_single_token();
        for (int n = 0; n < BEATS_PER_PHASE; n++) begin
            x_mat[n] = (n < DIM) ? (n % 4) + 1 : 0;
            wq_m[n]  = ((n * 3) % 5) - 2;
            // same Q and K weights keep the score positive
            wk_m[n]  = wq_m[n];
            wv_m[n]  = (n % 3) - 1;
        end
        run_sequence("single_token", 1);
    endtask

    task automatic test_full_sequence();
        fill_random();
        run_sequence("full_sequence", 8);
    endtask

    task automatic test_relu();
        fill_random();
        // non-negative Q makes every q.k with K = -Q at most zero
        for (int n = 0; n < BEATS_PER_PHASE; n++) begin
            if (x_mat[n] < 0) begin
                x_mat[n] = (x_mat[n] == -128) ? 127 : -x_mat[n];
            end
            if (wq_m[n] < 0) begin
                wq_m[n] = (wq_m[n] == -128) ? 127 : -wq_m[n];
            end
            wk_m[n] = -wq_m[n];
        end
        run_sequence("relu", 4);
    endtask

    task automatic test_masking();
        fill_random();
        // ignored beats carry nonzero data
        for (int n = 24; n < BEATS_PER_PHASE; n++) begin
            if (x_mat[n] == 0) begin
                x_mat[n] = 1;
            end
        end
        run_sequence("masking", 3);
    endtask

    task automatic test_back_to_back();
        fill_random();
        run_sequence("back_to_back_t8", 8);
        fill_random();
        run_sequence("back_to_back_t2", 2);
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        seq_len  = '0;
        in_data  = '0;
        w_q      = '0;
        w_k      = '0;
        w_v      = '0;
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        check_reset_state();
        test_single_token();
        test_full_sequence();
        test_relu();
        test_masking();
        test_back_to_back();

        $display("data errors: %0d, protocol errors: %0d", data_errors, proto_errors);
        if (data_errors + proto_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
